// File: project.f
+incdir+src
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/icache_assertions.sv
sim/tb_icache.sv

// File: Makefile
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_icache
RTL_TOP    = icache_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+100
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)); echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_icache.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module tb_icache;

	import icache_pkg::*;

	localparam int TIMEOUT_CYC  = 200; // per fetch including the refill
	localparam int RAND_FETCHES = 400;

	logic                      clk;
	logic                      rst_n;
	logic [`ICACHE_ADDR_W-1:0] cpu_req_addr;
	logic                      cpu_req_valid;
	logic [`ICACHE_DATA_W-1:0] cpu_data_read;
	logic                      cpu_ready;
	logic [`ICACHE_ADDR_W-1:0] mem_req_addr;
	logic                      mem_req_valid;
	logic [`ICACHE_DATA_W-1:0] mem_data_read;
	logic                      mem_ready;

	integer      seed;
	string       test_name;
	fetch_addr_t cur_addr; // fetch in flight
	int          errors;
	int          checks;
	int          data_errors;
	int          data_checks;
	int          mem_errors;
	int          timeouts;
	int          refills;   // mem_req_valid pulses seen by the memory model
	int          seen_misses;
	int          model_misses;
	logic [`ICACHE_ADDR_W-1:0] last_line;

	// expected tag side state
	bit                       model_valid [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_TAG_W-1:0] model_tag [`ICACHE_WAYS][`ICACHE_SETS];
	bit                       model_lru [`ICACHE_SETS];

	icache_top DUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req_addr  (cpu_req_addr),
		.cpu_req_valid (cpu_req_valid),
		.cpu_data_read (cpu_data_read),
		.cpu_ready     (cpu_ready),
		.mem_req_addr  (mem_req_addr),
		.mem_req_valid (mem_req_valid),
		.mem_data_read (mem_data_read),
		.mem_ready     (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory contents as a fixed pattern over the whole word address
	function automatic logic [63:0] mem_word(input logic [31:0] addr);
		logic [31:0] w;
		w = {3'b000, addr[31:3]};
		return {w ^ 32'ha5c3_0f1e, (w * 32'h9e37_79b9) + 32'h1234_5678};
	endfunction

	// a fetch returns the memory word that holds the address
	function automatic logic [63:0] expected_word(input logic [31:0] addr);
		return mem_word({addr[31:3], 3'b000});
	endfunction

	task automatic clear_model();
		int s;
		for (s = 0; s < `ICACHE_SETS; s++) begin
			model_valid[0][s] = 1'b0;
			model_valid[1][s] = 1'b0;
			model_tag[0][s]   = '0;
			model_tag[1][s]   = '0;
			model_lru[s]      = 1'b0;
		end
	endtask

	// predicts hit or miss and fills the empty way first, the lru way otherwise
	task automatic predict_access(input fetch_addr_t a, output bit hit);
		logic [`ICACHE_INDEX_W-1:0] idx;
		bit way;
		int w;
		idx = a.fields.index;
		hit = 1'b0;
		way = 1'b0;
		for (w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_valid[w][idx] && model_tag[w][idx] == a.fields.tag) begin
				hit = 1'b1;
				way = w[0];
			end
		end
		if (!hit) begin
			if (!model_valid[0][idx])
				way = 1'b0;
			else if (!model_valid[1][idx])
				way = 1'b1;
			else
				way = model_lru[idx];
			model_valid[way][idx] = 1'b1;
			model_tag[way][idx]   = a.fields.tag;
		end
		model_lru[idx] = ~way; // points away from the way just used
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		clear_model();
	endtask

	// one CPU fetch where lat counts the cycles from request to cpu_ready
	task automatic fetch(input logic [31:0] addr, output int lat, output bit missed);
		int cyc;
		int refills_before;
		bit exp_hit;
		lat    = 0;
		missed = 1'b0;
		if (timeouts != 0)
			return; // cache already stuck
		@(negedge clk);
		cur_addr.raw   = addr;
		cpu_req_addr   = addr;
		cpu_req_valid  = 1'b1;
		refills_before = refills;
		predict_access(cur_addr, exp_hit);
		for (cyc = 1; cyc <= TIMEOUT_CYC; cyc++) begin
			@(negedge clk);
			if (cpu_ready)
				break;
		end
		if (cyc > TIMEOUT_CYC) begin
			timeouts++;
			$display("%s: no cpu_ready within %0d cycles for address %h",
				test_name, TIMEOUT_CYC, addr);
		end else begin
			cpu_req_valid = 1'b0;
			lat    = cyc;
			missed = (refills != refills_before);
			checks++;
			assert (missed == !exp_hit) else begin
				errors++;
				$display("FAIL %s: address %h expected miss %0d, actual miss %0d",
					test_name, addr, !exp_hit, missed);
			end
			if (missed)
				seen_misses++;
			if (!exp_hit)
				model_misses++;
		end
	endtask

	// fetch with a known outcome where hits answer in one cycle
	task automatic fetch_expect(input logic [31:0] addr, input bit exp_miss);
		int lat;
		bit missed;
		fetch(addr, lat, missed);
		if (timeouts != 0)
			return;
		checks++;
		assert (missed == exp_miss) else begin
			errors++;
			$display("FAIL %s: address %h expected miss %0d, actual miss %0d",
				test_name, addr, exp_miss, missed);
		end
		if (!exp_miss) begin
			checks++;
			assert (lat == 1) else begin
				errors++;
				$display("FAIL %s: address %h expected latency 1, actual latency %0d",
					test_name, addr, lat);
			end
		end
	endtask

	// burst memory with a random delay and random gaps between four beats in order
	initial begin : memory_model
		logic [31:0] line;
		int delay;
		int gap;
		int b;
		mem_ready     = 1'b0;
		mem_data_read = '0;
		mem_errors    = 0;
		refills       = 0;
		last_line     = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req_valid) begin
				line      = mem_req_addr;
				last_line = line;
				refills++;
				assert (line == {cur_addr.raw[31:5], 5'b00000}) else begin
					mem_errors++;
					$display("FAIL %s: expected refill line %h, actual %h",
						test_name, {cur_addr.raw[31:5], 5'b00000}, line);
				end
				delay = 1 + ($random(seed) & 3);
				repeat (delay) @(negedge clk);
				for (b = 0; b < `ICACHE_BEATS; b++) begin
					mem_ready     = 1'b1;
					mem_data_read = mem_word(line + b * 8);
					@(negedge clk);
					mem_ready     = 1'b0;
					mem_data_read = '0;
					if (b < `ICACHE_BEATS - 1) begin
						gap = $random(seed) & 3;
						repeat (gap) @(negedge clk);
					end
				end
			end
		end
	end

	// every answer checked against the reference word
	always @(negedge clk) begin : compare_data
		if (rst_n && cpu_ready) begin
			data_checks++;
			assert (cpu_data_read == expected_word(cur_addr.raw)) else begin
				data_errors++;
				$display("FAIL %s: address %h expected %h, actual %h", test_name,
					cur_addr.raw, expected_word(cur_addr.raw), cpu_data_read);
			end
		end
	end

	initial begin : main
		int lat;
		bit missed;
		int i;
		int total;
		logic [31:0] r;
		logic [31:0] addr;
		seed          = 32'h900d2c32;
		errors        = 0;
		checks        = 0;
		data_errors   = 0;
		data_checks   = 0;
		timeouts      = 0;
		seen_misses   = 0;
		model_misses  = 0;
		test_name     = "reset";
		cur_addr.raw  = '0;
		cpu_req_addr  = '0;
		cpu_req_valid = 1'b0;
		apply_reset();

		test_name = "cold_miss";
		fetch(32'h0000_1048, lat, missed);
		checks++;
		assert (missed && last_line == 32'h0000_1040) else begin
			errors++;
			$display("FAIL %s: expected refill of line %h, actual miss %0d line %h",
				test_name, 32'h0000_1040, missed, last_line);
		end

		test_name = "same_line_hits";
		fetch_expect(32'h0000_1040, 1'b0);
		fetch_expect(32'h0000_1050, 1'b0);
		fetch_expect(32'h0000_1058, 1'b0);

		// three tags on set 5
		test_name = "lru_eviction";
		fetch_expect(32'h0000_80a0, 1'b1);
		fetch_expect(32'h0001_00a8, 1'b1);
		fetch_expect(32'h0001_00b0, 1'b0); // both resident
		fetch_expect(32'h0000_80b8, 1'b0); // lru now on the second tag
		fetch_expect(32'h0001_80a0, 1'b1);
		fetch_expect(32'h0000_80a8, 1'b0); // survivor
		fetch_expect(32'h0001_00a0, 1'b1); // evicted one comes back

		test_name    = "random_fetches";
		seen_misses  = 0;
		model_misses = 0;
		for (i = 0; i < RAND_FETCHES; i++) begin
			r          = $random(seed);
			addr       = 32'h0010_0000;
			addr[12:11] = r[5:4]; // four tags
			addr[6:5]  = r[3:2];  // over four sets
			addr[4:3]  = r[1:0];
			fetch(addr, lat, missed);
		end
		checks++;
		assert (seen_misses == model_misses) else begin
			errors++;
			$display("FAIL %s: expected %0d misses, actual %0d",
				test_name, model_misses, seen_misses);
		end

		test_name = "after_reset";
		apply_reset();
		fetch_expect(32'h0000_1048, 1'b1);

		total = errors + data_errors + mem_errors + timeouts
			+ DUT.u_assertions.fail_count;
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks + data_checks, errors + data_errors + mem_errors, timeouts,
			DUT.u_assertions.fail_count);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: sim/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions (
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid,
	input logic cpu_ready,
	input logic mem_req_valid,
	input logic mem_ready
);

	int unsigned fail_count = 0; // read by the testbench at the end

	bit       in_reset_q; // reset seen at the previous edge
	bit       refill_busy;
	bit [1:0] beats_seen;

	always_ff @(posedge clk) begin
		in_reset_q <= !rst_n;
	end

	// refill window, from the request pulse to the fourth beat
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			refill_busy <= 1'b0;
			beats_seen  <= 2'd0;
		end else if (mem_req_valid) begin
			refill_busy <= 1'b1;
			beats_seen  <= 2'd0;
		end else if (refill_busy && mem_ready) begin
			beats_seen <= beats_seen + 2'd1;
			if (beats_seen == 2'd3)
				refill_busy <= 1'b0; // fourth beat
		end
	end

	a_mem_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |=> !mem_req_valid)
	else begin
		$error("mem_req_valid held for more than one cycle");
		fail_count++;
	end

	a_ready_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> $past(cpu_req_valid))
	else begin
		$error("cpu_ready without a pending request");
		fail_count++;
	end

	a_no_ready_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req_valid || refill_busy) |-> !cpu_ready)
	else begin
		$error("cpu_ready during a refill");
		fail_count++;
	end

	a_quiet_in_reset: assert property (@(posedge clk)
		(in_reset_q && !rst_n) |-> (!cpu_ready && !mem_req_valid))
	else begin
		$error("control outputs active during reset");
		fail_count++;
	end

endmodule

bind icache_top icache_assertions u_assertions (
	.clk           (clk),
	.rst_n         (rst_n),
	.cpu_req_valid (cpu_req_valid),
	.cpu_ready     (cpu_ready),
	.mem_req_valid (mem_req_valid),
	.mem_ready     (mem_ready)
);

// File: src/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`ICACHE_ADDR_W-1:0] cpu_req_addr,
	input  logic                      cpu_req_valid,
	output logic [`ICACHE_DATA_W-1:0] cpu_data_read,
	output logic                      cpu_ready,
	output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
	output logic                      mem_req_valid,
	input  logic [`ICACHE_DATA_W-1:0] mem_data_read,
	input  logic                      mem_ready
);

	import icache_pkg::*;

	fetch_addr_t               req_addr; // latched request, feeds both arrays
	logic                      hit;
	logic                      hit_way;
	logic                      victim_way;
	logic                      lookup;
	logic                      fill_en;
	logic [`ICACHE_BEAT_W-1:0] fill_beat;
	logic                      tag_write;

	icache_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req_addr  (cpu_req_addr),
		.cpu_req_valid (cpu_req_valid),
		.cpu_ready     (cpu_ready),
		.mem_req_addr  (mem_req_addr),
		.mem_req_valid (mem_req_valid),
		.mem_ready     (mem_ready),
		.hit           (hit),
		.req_addr      (req_addr),
		.lookup        (lookup),
		.fill_en       (fill_en),
		.fill_beat     (fill_beat),
		.tag_write     (tag_write)
	);

	icache_tag_array u_tag_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_addr   (req_addr),
		.lookup     (lookup),
		.tag_write  (tag_write),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way)
	);

	// refill way is the victim held since the miss
	icache_data_array u_data_array (
		.clk           (clk),
		.req_addr      (req_addr),
		.fill_en       (fill_en),
		.fill_way      (victim_way),
		.fill_beat     (fill_beat),
		.mem_data_read (mem_data_read),
		.hit_way       (hit_way),
		.cpu_data_read (cpu_data_read)
	);

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`ICACHE_ADDR_W-1:0] cpu_req_addr,
	input  logic                      cpu_req_valid,
	output logic                      cpu_ready,
	output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
	output logic                      mem_req_valid,
	input  logic                      mem_ready,
	input  logic                      hit,
	output icache_pkg::fetch_addr_t   req_addr,
	output logic                      lookup,
	output logic                      fill_en,
	output logic [`ICACHE_BEAT_W-1:0] fill_beat,
	output logic                      tag_write
);

	import icache_pkg::*;

	ctrl_state_t               state;
	ctrl_state_t               next_state;
	logic [`ICACHE_BEAT_W-1:0] beat_cnt;
	logic                      last_beat;
	logic                      miss;

	// request register, loaded only while idle
	always_ff @(posedge clk) begin
		if (state == IDLE && cpu_req_valid)
			req_addr.raw <= cpu_req_addr;
	end

	assign lookup = (state == LOOKUP) || (state == RECHECK);
	assign miss   = lookup && !hit;

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cpu_req_valid)
					next_state = LOOKUP;
			end
			LOOKUP, RECHECK: begin
				if (hit)
					next_state = IDLE;
				else
					next_state = REFILL; // recheck miss refills again
			end
			REFILL: begin
				if (last_beat)
					next_state = RECHECK;
			end
			default: next_state = IDLE;
		endcase
	end

	// hit answers in the compare cycle itself
	assign cpu_ready = lookup && hit;

	// request pulse in the first refill cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			mem_req_valid <= 1'b0;
		else
			mem_req_valid <= miss;
	end

	assign mem_req_addr = {req_addr.raw[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
		{`ICACHE_OFFSET_W{1'b0}}}; // line aligned

	// beat counting, no back-pressure toward memory
	assign fill_en   = (state == REFILL) && mem_ready;
	assign last_beat = fill_en && (beat_cnt == `ICACHE_BEAT_W'(`ICACHE_BEATS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n)
			beat_cnt <= '0;
		else if (miss)
			beat_cnt <= '0; // fresh burst
		else if (fill_en)
			beat_cnt <= beat_cnt + 1'b1;
	end

	assign fill_beat = beat_cnt;
	assign tag_write = last_beat; // tag goes valid with the fourth beat

endmodule

// File: src/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_data_array (
	input  logic                      clk,
	input  icache_pkg::fetch_addr_t   req_addr,
	input  logic                      fill_en,
	input  logic                      fill_way,
	input  logic [`ICACHE_BEAT_W-1:0] fill_beat,
	input  logic [`ICACHE_DATA_W-1:0] mem_data_read,
	input  logic                      hit_way,
	output logic [`ICACHE_DATA_W-1:0] cpu_data_read
);

	// one line is four words, beat n holds word n
	logic [`ICACHE_DATA_W-1:0]  line_mem [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_BEATS];
	logic [`ICACHE_INDEX_W-1:0] idx;

	assign idx = req_addr.fields.index;

	// refill write, one beat per mem_ready
	always_ff @(posedge clk) begin
		if (fill_en)
			line_mem[fill_way][idx][fill_beat] <= mem_data_read;
	end

	// word select on the hit way
	assign cpu_data_read = line_mem[hit_way][idx][req_addr.fields.word_sel];

endmodule

// File: src/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tag_array (
	input  logic                    clk,
	input  logic                    rst_n,
	input  icache_pkg::fetch_addr_t req_addr,
	input  logic                    lookup,
	input  logic                    tag_write,
	output logic                    hit,
	output logic                    hit_way,
	output logic                    victim_way
);

	logic [`ICACHE_SETS-1:0]    valid_mem [`ICACHE_WAYS];
	logic [`ICACHE_TAG_W-1:0]   tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0]    lru_mem; // per set, the way to evict next
	logic [`ICACHE_WAYS-1:0]    way_hit;
	logic [`ICACHE_INDEX_W-1:0] idx;
	logic                       victim_next;
	logic                       victim_q;

	assign idx = req_addr.fields.index;

	// compare both ways of the addressed set
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_hit[w] = valid_mem[w][idx] && (tag_mem[w][idx] == req_addr.fields.tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1]; // only meaningful with hit

	// empty way first, way 0 before way 1
	always_comb begin
		if (!valid_mem[0][idx])
			victim_next = 1'b0;
		else if (!valid_mem[1][idx])
			victim_next = 1'b1;
		else
			victim_next = lru_mem[idx];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_mem[w] <= '0;
				for (int s = 0; s < `ICACHE_SETS; s++) begin
					tag_mem[w][s] <= '0;
				end
			end
			lru_mem  <= '0;
			victim_q <= 1'b0;
		end else begin
			// miss, remember where the refill goes
			if (lookup && !hit)
				victim_q <= victim_next;

			if (lookup && hit)
				lru_mem[idx] <= ~hit_way; // point at the other way

			// last beat in, the line becomes visible
			if (tag_write) begin
				valid_mem[victim_q][idx] <= 1'b1;
				tag_mem[victim_q][idx]   <= req_addr.fields.tag;
				lru_mem[idx]             <= ~victim_q;
			end
		end
	end

	assign victim_way = victim_q;

endmodule

// File: src/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

	// field view of a fetch address, msb first
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0]      tag;
		logic [`ICACHE_INDEX_W-1:0]    index;
		logic [`ICACHE_WORD_SEL_W-1:0] word_sel; // beat number within the line
		logic [`ICACHE_BYTE_W-1:0]     byte_sel; // always zero for word fetches
	} fetch_fields_t;

	// flat word for the memory port, fields for the arrays
	typedef union packed {
		logic [`ICACHE_ADDR_W-1:0] raw;
		fetch_fields_t             fields;
	} fetch_addr_t;

	// controller states
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		LOOKUP  = 2'd1, // first compare, hit answers here
		REFILL  = 2'd2, // waiting on the four memory beats
		RECHECK = 2'd3  // compare again after the line is in
	} ctrl_state_t;

endpackage

// File: src/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address and data path
`define ICACHE_ADDR_W     32
`define ICACHE_DATA_W     64

// 64 sets of 32-byte lines, two ways per set
`define ICACHE_INDEX_W    6
`define ICACHE_SETS       (1 << `ICACHE_INDEX_W)
`define ICACHE_WAYS       2
`define ICACHE_OFFSET_W   5
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// offset split into 64-bit word and byte within word
`define ICACHE_WORD_SEL_W 2
`define ICACHE_BYTE_W     3

`define ICACHE_BEATS      4 // refill burst length
`define ICACHE_BEAT_W     2

`endif
